/* src/mopshub_pkg.sv */
`default_nettype none

package mopshub_pkg;

  // Hub size and line format
  localparam int N_BUSES     = 8;
  localparam int BUS_ID_BITS = 5;
  localparam int MSG_BITS    = 71;

  // Queue depths and credit amounts
  localparam int DOWN_DEPTH = 4;
  localparam int CHAN_DEPTH = 2;
  localparam int UP_CREDITS = 4;

  // Message as it travels on a bus line, MSB first
  typedef struct packed {
    logic [10:0] id;
    logic [3:0]  len;
    logic [55:0] payload;
  } can_msg_t;

  // Link-side frame, same layout in both directions
  typedef struct packed {
    logic [BUS_ID_BITS-1:0] bus_id;
    can_msg_t               msg;
  } elink_frame_t;

  // One bit per bus
  typedef logic [N_BUSES-1:0] bus_mask_t;

endpackage

`default_nettype wire

/* src/credit_fifo.sv */
`default_nettype none

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  wire      clk,
  input  wire      rst,
  input  wire      in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  wire      out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t           mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_wr;
  logic               do_rd;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign do_wr = in_valid && in_ready;
  assign do_rd = out_valid && out_ready;

  // Storage array
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Occupancy holds when both sides move
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/can_channel.sv */
`default_nettype none

module can_channel (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   tx_valid,
  output logic                  tx_ready,
  input  mopshub_pkg::can_msg_t tx_msg,
  output logic                  tx,
  input  wire                   rx,
  output logic                  rx_valid,
  input  wire                   rx_ready,
  output mopshub_pkg::can_msg_t rx_msg
);

  localparam int CNT_W = $clog2(mopshub_pkg::MSG_BITS + 1);

  mopshub_pkg::can_msg_t         q_msg;
  logic                          q_valid;
  logic                          q_ready;

  logic                          tx_busy;
  logic [CNT_W-1:0]              tx_cnt;
  logic [mopshub_pkg::MSG_BITS:0] tx_shift;

  logic                          rx_busy;
  logic                          rx_full;
  logic [CNT_W-1:0]              rx_cnt;
  logic [mopshub_pkg::MSG_BITS-1:0] rx_shift;

  credit_fifo #(
    .payload_t (mopshub_pkg::can_msg_t),
    .DEPTH     (mopshub_pkg::CHAN_DEPTH)
  ) tx_fifo_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (tx_valid),
    .in_ready  (tx_ready),
    .in_data   (tx_msg),
    .out_valid (q_valid),
    .out_ready (q_ready),
    .out_data  (q_msg)
  );

  // Serializer takes a new message only when idle
  assign q_ready = !tx_busy;
  assign tx      = tx_busy ? tx_shift[mopshub_pkg::MSG_BITS] : 1'b1;

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      tx_busy <= 1'b0;
      tx_cnt  <= '0;
    end
    else if (!tx_busy)
    begin
      if (q_valid)
      begin
        tx_busy <= 1'b1;
        tx_cnt  <= '0;
      end
    end
    else if (tx_cnt == CNT_W'(mopshub_pkg::MSG_BITS))
      tx_busy <= 1'b0;
    else
      tx_cnt <= tx_cnt + 1'b1;
  end

  // Start bit in front of the message
  always_ff @(posedge clk)
  begin
    if (!tx_busy)
      tx_shift <= {1'b0, q_msg};
    else
      tx_shift <= {tx_shift[mopshub_pkg::MSG_BITS-1:0], 1'b1};
  end

  // Receive side, shift register doubles as holding register
  assign rx_valid = rx_full;
  assign rx_msg   = rx_shift;

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      rx_busy <= 1'b0;
      rx_full <= 1'b0;
      rx_cnt  <= '0;
    end
    else
    begin
      if (rx_full && rx_ready)
        rx_full <= 1'b0;
      if (!rx_busy && !rx_full && !rx)
      begin
        rx_busy <= 1'b1;
        rx_cnt  <= '0;
      end
      else if (rx_busy)
      begin
        if (rx_cnt == CNT_W'(mopshub_pkg::MSG_BITS - 1))
        begin
          rx_busy <= 1'b0;
          rx_full <= 1'b1;
        end
        rx_cnt <= rx_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_busy)
      rx_shift <= {rx_shift[mopshub_pkg::MSG_BITS-2:0], rx};
  end

endmodule

`default_nettype wire

/* src/downlink_router.sv */
`default_nettype none

module downlink_router (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       in_valid,
  output logic                      in_ready,
  input  mopshub_pkg::elink_frame_t in_data,
  output mopshub_pkg::bus_mask_t    chan_valid,
  input  mopshub_pkg::bus_mask_t    chan_ready,
  output mopshub_pkg::can_msg_t     chan_msg,
  output logic                      down_credit,
  output logic [7:0]                drop_count
);

  logic                   bus_ok;
  mopshub_pkg::bus_mask_t sel_mask;
  logic                   consumed;

  assign bus_ok = (in_data.bus_id <
                   mopshub_pkg::BUS_ID_BITS'(mopshub_pkg::N_BUSES));

  // One-hot channel select, empty for a bad bus number
  assign sel_mask = bus_ok ? (mopshub_pkg::bus_mask_t'(1) << in_data.bus_id) : '0;

  assign chan_valid = in_valid ? sel_mask : '0;
  assign chan_msg   = in_data.msg;

  // Bad frames are taken at once, good ones wait for the channel
  assign in_ready = !bus_ok || (|(chan_ready & sel_mask));
  assign consumed = in_valid && in_ready;

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      down_credit <= 1'b0;
      drop_count  <= '0;
    end
    else
    begin
      down_credit <= consumed;
      // Saturates at 255
      if (in_valid && !bus_ok && drop_count != 8'hFF)
        drop_count <= drop_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/uplink_arbiter.sv */
`default_nettype none

module uplink_arbiter (
  input  wire                       clk,
  input  wire                       rst,
  input  mopshub_pkg::bus_mask_t    req,
  output mopshub_pkg::bus_mask_t    grant,
  input  mopshub_pkg::can_msg_t     req_msg [mopshub_pkg::N_BUSES],
  output logic                      up_valid,
  output mopshub_pkg::elink_frame_t up_data,
  input  wire                       up_credit
);

  localparam int IDX_W = $clog2(mopshub_pkg::N_BUSES);
  localparam int CNT_W = $clog2(mopshub_pkg::UP_CREDITS + 1);

  logic [IDX_W-1:0] last_ptr;
  logic [IDX_W-1:0] win;
  logic             found;
  logic [CNT_W-1:0] credit_cnt;

  // Search starts just after the channel served last
  always_comb
  begin
    int cand;
    found = 1'b0;
    win   = last_ptr;
    for (int i = 1; i <= mopshub_pkg::N_BUSES; i++)
    begin
      cand = (int'(last_ptr) + i) % mopshub_pkg::N_BUSES;
      if (!found && req[cand])
      begin
        found = 1'b1;
        win   = IDX_W'(cand);
      end
    end
  end

  assign up_valid = found && (credit_cnt != '0);
  assign grant    = up_valid ? (mopshub_pkg::bus_mask_t'(1) << win) : '0;

  // Channel index becomes the bus number
  assign up_data.bus_id = mopshub_pkg::BUS_ID_BITS'(win);
  assign up_data.msg    = req_msg[win];

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      last_ptr   <= IDX_W'(mopshub_pkg::N_BUSES - 1);
      credit_cnt <= CNT_W'(mopshub_pkg::UP_CREDITS);
    end
    else
    begin
      if (up_valid)
        last_ptr <= win;
      case ({up_credit, up_valid})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/mopshub_core.sv */
`default_nettype none

module mopshub_core (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       down_valid,
  input  mopshub_pkg::elink_frame_t down_data,
  output logic                      down_credit,
  output logic                      up_valid,
  output mopshub_pkg::elink_frame_t up_data,
  input  wire                       up_credit,
  input  mopshub_pkg::bus_mask_t    rx,
  output mopshub_pkg::bus_mask_t    tx,
  output logic [7:0]                drop_count
);

  // Downlink queue to router
  logic                      q_valid;
  logic                      q_ready;
  mopshub_pkg::elink_frame_t q_frame;

  // Router to channels
  mopshub_pkg::bus_mask_t    chan_valid;
  mopshub_pkg::bus_mask_t    chan_ready;
  mopshub_pkg::can_msg_t     chan_msg;

  // Channels to arbiter
  mopshub_pkg::bus_mask_t    rx_req;
  mopshub_pkg::bus_mask_t    rx_grant;
  mopshub_pkg::can_msg_t     rx_msg [mopshub_pkg::N_BUSES];

  // Never full while the link side respects its credits
  credit_fifo #(
    .payload_t (mopshub_pkg::elink_frame_t),
    .DEPTH     (mopshub_pkg::DOWN_DEPTH)
  ) down_fifo_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (down_valid),
    .in_ready  (),
    .in_data   (down_data),
    .out_valid (q_valid),
    .out_ready (q_ready),
    .out_data  (q_frame)
  );

  downlink_router downlink_router_inst (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (q_valid),
    .in_ready    (q_ready),
    .in_data     (q_frame),
    .chan_valid  (chan_valid),
    .chan_ready  (chan_ready),
    .chan_msg    (chan_msg),
    .down_credit (down_credit),
    .drop_count  (drop_count)
  );

  for (genvar b = 0; b < mopshub_pkg::N_BUSES; b++)
  begin : gen_chan
    can_channel can_channel_inst (
      .clk      (clk),
      .rst      (rst),
      .tx_valid (chan_valid[b]),
      .tx_ready (chan_ready[b]),
      .tx_msg   (chan_msg),
      .tx       (tx[b]),
      .rx       (rx[b]),
      .rx_valid (rx_req[b]),
      .rx_ready (rx_grant[b]),
      .rx_msg   (rx_msg[b])
    );
  end

  uplink_arbiter uplink_arbiter_inst (
    .clk       (clk),
    .rst       (rst),
    .req       (rx_req),
    .grant     (rx_grant),
    .req_msg   (rx_msg),
    .up_valid  (up_valid),
    .up_data   (up_data),
    .up_credit (up_credit)
  );

endmodule

`default_nettype wire

/* testbench/mopshub_core_properties.sv */
`default_nettype none

module mopshub_core_properties (
  input wire                         clk,
  input wire                         rst,
  input wire                         up_valid,
  input wire                         up_credit,
  input wire mopshub_pkg::bus_mask_t tx,
  input wire [7:0]                   drop_count
);

  // Uplink credits as the link side sees them
  int credits;

  always_ff @(posedge clk)
  begin
    if (!rst)
      credits <= mopshub_pkg::UP_CREDITS;
    else
      credits <= credits + int'(up_credit) - int'(up_valid);
  end

  assert property (@(posedge clk) disable iff (!rst) up_valid |-> credits > 0)
    else $error("up_valid raised with no uplink credits");

  // Lines idle from the first reset edge on
  assert property (@(posedge clk) !rst |=> tx == '1)
    else $error("tx line not idle during reset");

  assert property (@(posedge clk) disable iff (!rst) drop_count >= $past(drop_count))
    else $error("drop_count decreased");

endmodule

bind mopshub_core mopshub_core_properties mopshub_core_properties_inst (
  .clk        (clk),
  .rst        (rst),
  .up_valid   (up_valid),
  .up_credit  (up_credit),
  .tx         (tx),
  .drop_count (drop_count)
);

`default_nettype wire

/* testbench/tb_mopshub_core.sv */
`default_nettype none

module tb_mopshub_core;

  typedef struct packed {
    logic        up;
    logic [4:0]  bus;
    logic [10:0] id;
    logic [3:0]  len;
    logic [3:0]  count;
    logic        drop;
    logic        hold;
  } row_t;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      down_valid;
  mopshub_pkg::elink_frame_t down_data;
  logic                      down_credit;
  logic                      up_valid;
  mopshub_pkg::elink_frame_t up_data;
  logic                      up_credit;
  mopshub_pkg::bus_mask_t    rx;
  mopshub_pkg::bus_mask_t    tx;
  logic [7:0]                drop_count;

  // Stimulus table, one row per test
  row_t  rows [$];
  string names [$];

  logic [31:0] rng;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          down_sent;
  logic        ran_out;
  logic        credit_release;
  int          credit_ret;
  int          credit_pulses;

  // Observed traffic
  mopshub_pkg::elink_frame_t        tx_seen [$];
  mopshub_pkg::elink_frame_t        up_q [$];
  logic                             mon_on  [mopshub_pkg::N_BUSES];
  int                               mon_cnt [mopshub_pkg::N_BUSES];
  int                               low_cnt [mopshub_pkg::N_BUSES];
  logic [mopshub_pkg::MSG_BITS-1:0] mon_sh  [mopshub_pkg::N_BUSES];

  mopshub_core mopshub_core_inst (
    .clk         (clk),
    .rst         (rst),
    .down_valid  (down_valid),
    .down_data   (down_data),
    .down_credit (down_credit),
    .up_valid    (up_valid),
    .up_data     (up_data),
    .up_credit   (up_credit),
    .rx          (rx),
    .tx          (tx),
    .drop_count  (drop_count)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_msg(input string name, input mopshub_pkg::can_msg_t exp,
                           input mopshub_pkg::can_msg_t act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_frame(input string name, input mopshub_pkg::elink_frame_t exp,
                             input mopshub_pkg::elink_frame_t act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act)
    begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic add_row(input string name, input bit up, input int bus, input int id,
                         input int len, input int count, input bit drop, input bit hold);
    row_t r;
    r.up    = up;
    r.bus   = 5'(bus);
    r.id    = 11'(id);
    r.len   = 4'(len);
    r.count = 4'(count);
    r.drop  = drop;
    r.hold  = hold;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic load_table();
    // Name, uplink, bus, id, length, frames, expect drop, hold credits
    add_row("route_bus0",  1'b0, 0,  'h123, 8, 1, 1'b0, 1'b0);
    add_row("route_bus5",  1'b0, 5,  'h2A5, 4, 1, 1'b0, 1'b0);
    add_row("route_bus7",  1'b0, 7,  'h7FF, 8, 1, 1'b0, 1'b0);
    add_row("uplink_bus2", 1'b1, 2,  'h041, 6, 1, 1'b0, 1'b0);
    add_row("uplink_bus6", 1'b1, 6,  'h3C0, 2, 1, 1'b0, 1'b0);
    add_row("drop_bus8",   1'b0, 8,  'h100, 8, 1, 1'b1, 1'b0);
    add_row("drop_bus31",  1'b0, 31, 'h555, 1, 1, 1'b1, 1'b0);
    add_row("burst_bus3",  1'b0, 3,  'h0F0, 8, 8, 1'b0, 1'b0);
    add_row("uplink_held", 1'b1, 0,  'h222, 8, 6, 1'b0, 1'b1);
  endtask

  task automatic make_msg(input row_t r, output mopshub_pkg::can_msg_t m);
    logic [31:0] hi;
    rng = xorshift32(rng);
    hi  = rng;
    rng = xorshift32(rng);
    m.id      = r.id;
    m.len     = r.len;
    m.payload = {hi[23:0], rng};
  endtask

  // Waits for a downlink credit, then holds valid for one cycle
  task automatic send_frame(input mopshub_pkg::elink_frame_t f);
    while (mopshub_pkg::DOWN_DEPTH - down_sent + credit_pulses <= 0)
    begin
      ran_out = 1'b1;
      tick(1);
    end
    down_valid = 1'b1;
    down_data  = f;
    down_sent++;
    tick(1);
    down_valid = 1'b0;
  endtask

  // Start bit, then MSB first, one bit per clock
  task automatic drive_rx(input int b, input mopshub_pkg::can_msg_t m);
    logic [mopshub_pkg::MSG_BITS-1:0] bits;
    bits  = m;
    rx[b] = 1'b0;
    for (int i = mopshub_pkg::MSG_BITS - 1; i >= 0; i--)
    begin
      tick(1);
      rx[b] = bits[i];
    end
    tick(1);
    rx[b] = 1'b1;
    tick(2);
  endtask

  task automatic run_downlink(input row_t r, input string name);
    mopshub_pkg::can_msg_t     msg;
    mopshub_pkg::elink_frame_t frame;
    mopshub_pkg::can_msg_t     exp_q [$];
    int                        base_seen;
    int                        base_pulses;
    int                        base_drop;
    int                        low_base [mopshub_pkg::N_BUSES];
    base_seen   = tx_seen.size();
    base_pulses = credit_pulses;
    base_drop   = int'(drop_count);
    low_base    = low_cnt;
    ran_out     = 1'b0;
    for (int k = 0; k < int'(r.count); k++)
    begin
      make_msg(r, msg);
      exp_q.push_back(msg);
      frame.bus_id = r.bus;
      frame.msg    = msg;
      send_frame(frame);
    end
    while (credit_pulses < base_pulses + int'(r.count))
      tick(1);
    if (r.drop)
    begin
      tick(100);
      check_count({name, " drop_count"}, base_drop + int'(r.count), int'(drop_count));
      check_count({name, " frames on lines"}, base_seen, tx_seen.size());
    end
    else
    begin
      while (tx_seen.size() < base_seen + int'(r.count))
        tick(1);
      tick(4);
      check_count({name, " frames on lines"}, base_seen + int'(r.count), tx_seen.size());
      for (int k = 0; k < int'(r.count); k++)
      begin
        check_count({name, " bus"}, int'(r.bus), int'(tx_seen[base_seen + k].bus_id));
        check_msg(name, exp_q[k], tx_seen[base_seen + k].msg);
      end
      // Deep bursts must drain the link side's credits
      if (int'(r.count) > mopshub_pkg::DOWN_DEPTH + mopshub_pkg::CHAN_DEPTH + 1)
        check_count({name, " credits ran out"}, 1, int'(ran_out));
    end
    check_count({name, " credit pulses"}, base_pulses + int'(r.count), credit_pulses);
    for (int b = 0; b < mopshub_pkg::N_BUSES; b++)
    begin
      if (r.drop || b != int'(r.bus))
        check_count($sformatf("%s idle line %0d", name, b), low_base[b], low_cnt[b]);
    end
  endtask

  task automatic run_uplink(input row_t r, input string name);
    mopshub_pkg::elink_frame_t frame;
    mopshub_pkg::elink_frame_t exp_q [$];
    mopshub_pkg::elink_frame_t got [$];
    int                        base_up;
    int                        found;
    int                        held;
    base_up        = up_q.size();
    credit_release = !r.hold;
    for (int k = 0; k < int'(r.count); k++)
    begin
      make_msg(r, frame.msg);
      frame.bus_id = 5'(int'(r.bus) + k);
      exp_q.push_back(frame);
      drive_rx(int'(frame.bus_id), frame.msg);
    end
    if (r.hold)
    begin
      tick(20);
      held = (int'(r.count) < mopshub_pkg::UP_CREDITS) ? int'(r.count) : mopshub_pkg::UP_CREDITS;
      check_count({name, " frames while held"}, held, up_q.size() - base_up);
      credit_release = 1'b1;
    end
    while (up_q.size() < base_up + int'(r.count))
      tick(1);
    tick(20);
    check_count({name, " frame count"}, int'(r.count), up_q.size() - base_up);
    for (int j = base_up; j < up_q.size(); j++)
      got.push_back(up_q[j]);
    // Arrival order depends on the arbiter, so match by bus
    foreach (exp_q[i])
    begin
      found = -1;
      foreach (got[j])
      begin
        if (found < 0 && got[j].bus_id == exp_q[i].bus_id)
          found = j;
      end
      if (found < 0)
      begin
        $display("Test %s: no uplink frame arrived for bus %0d", name, exp_q[i].bus_id);
        errors++;
      end
      else
      begin
        check_frame(name, exp_q[i], got[found]);
        got.delete(found);
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before)
    begin
      $display("Test %s: ok", name);
      tests_passed++;
    end
    else
    begin
      $display("Test %s: failed", name);
      tests_failed++;
    end
  endtask

  // Line monitors rebuild messages from each tx line
  initial
  begin
    mopshub_pkg::elink_frame_t seen;
    for (int b = 0; b < mopshub_pkg::N_BUSES; b++)
    begin
      mon_on[b]  = 1'b0;
      mon_cnt[b] = 0;
      low_cnt[b] = 0;
    end
    forever
    begin
      @(negedge clk);
      for (int b = 0; b < mopshub_pkg::N_BUSES; b++)
      begin
        if (rst !== 1'b1)
          mon_on[b] = 1'b0;
        else if (mon_on[b])
        begin
          mon_sh[b] = {mon_sh[b][mopshub_pkg::MSG_BITS-2:0], tx[b]};
          mon_cnt[b]++;
          if (mon_cnt[b] == mopshub_pkg::MSG_BITS)
          begin
            seen.bus_id = 5'(b);
            seen.msg    = mon_sh[b];
            tx_seen.push_back(seen);
            mon_on[b] = 1'b0;
          end
        end
        else if (tx[b] === 1'b0)
        begin
          mon_on[b]  = 1'b1;
          mon_cnt[b] = 0;
        end
        if (rst === 1'b1 && tx[b] !== 1'b1)
          low_cnt[b]++;
      end
    end
  end

  // Downlink credit pulses and uplink frames
  initial
  begin
    credit_pulses = 0;
    forever
    begin
      @(negedge clk);
      if (rst === 1'b1 && down_credit === 1'b1)
        credit_pulses++;
      if (rst === 1'b1 && up_valid === 1'b1)
        up_q.push_back(up_data);
    end
  end

  // Returns one uplink credit per cycle while released
  initial
  begin
    up_credit  = 1'b0;
    credit_ret = 0;
    forever
    begin
      @(posedge clk);
      #1;
      if (credit_release && credit_ret < up_q.size())
      begin
        up_credit = 1'b1;
        credit_ret++;
      end
      else
        up_credit = 1'b0;
    end
  end

  initial
  begin
    @(posedge rst);
    repeat (rows.size() * 400 + 1000) @(posedge clk);
    $display("Timeout: the tests did not finish in the expected number of cycles");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    int err_before;
    rst            = 1'b0;
    down_valid     = 1'b0;
    down_data      = '0;
    rx             = '1;
    credit_release = 1'b1;
    rng            = 32'd24984;
    errors         = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    down_sent      = 0;
    ran_out        = 1'b0;
    load_table();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;

    @(negedge clk);
    err_before = errors;
    check_count("reset_state tx", 255, int'(tx));
    check_count("reset_state up_valid", 0, int'(up_valid));
    check_count("reset_state down_credit", 0, int'(down_credit));
    check_count("reset_state drop_count", 0, int'(drop_count));
    finish_test("reset_state", err_before);
    tick(1);

    for (int i = 0; i < rows.size(); i++)
    begin
      err_before = errors;
      if (rows[i].up)
        run_uplink(rows[i], names[i]);
      else
        run_downlink(rows[i], names[i]);
      finish_test(names[i], err_before);
    end

    $display("Tests %0d, passed %0d, failed %0d, check errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
src/mopshub_pkg.sv
src/credit_fifo.sv
src/can_channel.sv
src/downlink_router.sv
src/uplink_arbiter.sv
src/mopshub_core.sv
testbench/mopshub_core_properties.sv
testbench/tb_mopshub_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_mopshub_core -f sim.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi
